/* logic/dram_pkg.sv */
package dram_pkg;

  // word and bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int PC_W = 32;

  // four byte lanes make up one word
  localparam int LANES = 4;

  // memory size in words
  localparam int DEPTH = 256;
  localparam int INDEX_W = $clog2(DEPTH);

  typedef logic [DATA_W-1:0] word_t;

  typedef logic [ADDR_W-1:0] addr_t;

  // program counter of the issuing slot, used to order same-cycle stores
  typedef logic [PC_W-1:0] pc_t;

  typedef logic [LANES-1:0] sel_t;

  typedef logic [INDEX_W-1:0] index_t;

  typedef logic [DATA_W/LANES-1:0] byte_t;

endpackage

/* logic/dram_request_arbiter.sv */
module dram_request_arbiter
  import dram_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  input  logic   cyc_0,
  input  logic   stb_0,
  input  logic   we_0,
  input  addr_t  adr_0,
  input  sel_t   sel_0,
  input  word_t  dat_w_0,
  input  pc_t    pc_0,
  input  logic   ack_0,
  input  logic   err_0,

  input  logic   cyc_1,
  input  logic   stb_1,
  input  logic   we_1,
  input  addr_t  adr_1,
  input  sel_t   sel_1,
  input  word_t  dat_w_1,
  input  pc_t    pc_1,
  input  logic   ack_1,
  input  logic   err_1,

  output logic   accept_0,
  output logic   range_err_0,
  output sel_t   wr_en_0,
  output sel_t   rd_en_0,
  output index_t wr_index_0,
  output index_t rd_index_0,
  output word_t  wr_data_0,

  output logic   accept_1,
  output logic   range_err_1,
  output sel_t   wr_en_1,
  output sel_t   rd_en_1,
  output index_t wr_index_1,
  output index_t rd_index_1,
  output word_t  wr_data_1
);

  logic   live;
  index_t index_0;
  index_t index_1;
  sel_t   want_0;
  sel_t   want_1;
  sel_t   clash;
  logic   port0_later;

  // no acceptance until the cycle after reset releases,
  // so nothing is written while the response stage is held
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      live <= 1'b0;
    else
      live <= 1'b1;
  end

  assign index_0 = adr_0[INDEX_W+1:2];
  assign index_1 = adr_1[INDEX_W+1:2];

  // any address bit above the word index means beyond the memory
  assign range_err_0 = |adr_0[ADDR_W-1:INDEX_W+2];
  assign range_err_1 = |adr_1[ADDR_W-1:INDEX_W+2];

  // a pending ack or err blocks a held request from being taken twice
  assign accept_0 = live & cyc_0 & stb_0 & ~ack_0 & ~err_0;
  assign accept_1 = live & cyc_1 & stb_1 & ~ack_1 & ~err_1;

  assign want_0 = {LANES{accept_0 & we_0 & ~range_err_0}} & sel_0;
  assign want_1 = {LANES{accept_1 & we_1 & ~range_err_1}} & sel_1;

  // lanes that both ports write at the same word
  assign clash = want_0 & want_1 & {LANES{index_0 == index_1}};

  // larger pc is the later instruction; on a tie port 1 keeps the byte
  assign port0_later = pc_0 > pc_1;

  assign wr_en_0 = want_0 & ~(clash & {LANES{~port0_later}});
  assign wr_en_1 = want_1 & ~(clash & {LANES{port0_later}});

  assign rd_en_0 = {LANES{accept_0 & ~we_0 & ~range_err_0}};
  assign rd_en_1 = {LANES{accept_1 & ~we_1 & ~range_err_1}};

  assign wr_index_0 = index_0;
  assign rd_index_0 = index_0;
  assign wr_index_1 = index_1;
  assign rd_index_1 = index_1;

  assign wr_data_0 = dat_w_0;
  assign wr_data_1 = dat_w_1;

endmodule

/* logic/dram_byte_bank.sv */
module dram_byte_bank
  import dram_pkg::*;
(
  input  logic   clk,

  input  logic   wr_en_0,
  input  logic   wr_en_1,
  input  logic   rd_en_0,
  input  logic   rd_en_1,

  input  index_t wr_index_0,
  input  index_t wr_index_1,
  input  index_t rd_index_0,
  input  index_t rd_index_1,

  input  byte_t  wr_byte_0,
  input  byte_t  wr_byte_1,

  output byte_t  rd_byte_0,
  output byte_t  rd_byte_1
);

  byte_t mem [DEPTH];

  // the arbiter never enables both writes on the same index
  always_ff @(posedge clk)
  begin
    if (wr_en_0)
      mem[wr_index_0] <= wr_byte_0;
    if (wr_en_1)
      mem[wr_index_1] <= wr_byte_1;
  end

  // reads see the byte from before this edge's writes
  always_ff @(posedge clk)
  begin
    if (rd_en_0)
      rd_byte_0 <= mem[rd_index_0];
    else
      rd_byte_0 <= '0;
    if (rd_en_1)
      rd_byte_1 <= mem[rd_index_1];
    else
      rd_byte_1 <= '0;
  end

endmodule

/* logic/dram_response.sv */
module dram_response
  import dram_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  input  logic  accept_0,
  input  logic  accept_1,
  input  logic  range_err_0,
  input  logic  range_err_1,
  input  logic  we_0,
  input  logic  we_1,

  // one byte per lane, lane 0 is the low byte of the word
  input  byte_t rd_byte_0 [LANES],
  input  byte_t rd_byte_1 [LANES],

  output logic  ack_0,
  output logic  ack_1,
  output logic  err_0,
  output logic  err_1,
  output word_t dat_r_0,
  output word_t dat_r_1
);

  logic  rd_pend_0;
  logic  rd_pend_1;
  word_t word_0;
  word_t word_1;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ack_0     <= 1'b0;
      ack_1     <= 1'b0;
      err_0     <= 1'b0;
      err_1     <= 1'b0;
      rd_pend_0 <= 1'b0;
      rd_pend_1 <= 1'b0;
    end
    else
    begin
      ack_0     <= accept_0 & ~range_err_0;
      ack_1     <= accept_1 & ~range_err_1;
      err_0     <= accept_0 & range_err_0;
      err_1     <= accept_1 & range_err_1;
      rd_pend_0 <= accept_0 & ~range_err_0 & ~we_0;
      rd_pend_1 <= accept_1 & ~range_err_1 & ~we_1;
    end
  end

  always_comb
  begin
    for (int k = 0; k < LANES; k++)
    begin
      word_0[k*(DATA_W/LANES) +: DATA_W/LANES] = rd_byte_0[k];
      word_1[k*(DATA_W/LANES) +: DATA_W/LANES] = rd_byte_1[k];
    end
  end

  // zero unless a read ack is on the bus
  assign dat_r_0 = rd_pend_0 ? word_0 : '0;
  assign dat_r_1 = rd_pend_1 ? word_1 : '0;

endmodule

/* logic/data_ram.sv */
module data_ram
  import dram_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  input  logic  cyc_0,
  input  logic  stb_0,
  input  logic  we_0,
  input  addr_t adr_0,
  input  sel_t  sel_0,
  input  word_t dat_w_0,
  input  pc_t   pc_0,
  output word_t dat_r_0,
  output logic  ack_0,
  output logic  err_0,

  input  logic  cyc_1,
  input  logic  stb_1,
  input  logic  we_1,
  input  addr_t adr_1,
  input  sel_t  sel_1,
  input  word_t dat_w_1,
  input  pc_t   pc_1,
  output word_t dat_r_1,
  output logic  ack_1,
  output logic  err_1
);

  logic   accept_0;
  logic   accept_1;
  logic   range_err_0;
  logic   range_err_1;
  sel_t   wr_en_0;
  sel_t   wr_en_1;
  sel_t   rd_en_0;
  sel_t   rd_en_1;
  index_t wr_index_0;
  index_t wr_index_1;
  index_t rd_index_0;
  index_t rd_index_1;
  word_t  wr_data_0;
  word_t  wr_data_1;
  byte_t  rd_byte_0 [LANES];
  byte_t  rd_byte_1 [LANES];

  dram_request_arbiter arbiter0 (
    .clk(clk), .rst_n(rst_n),
    .cyc_0(cyc_0), .stb_0(stb_0), .we_0(we_0), .adr_0(adr_0), .sel_0(sel_0),
    .dat_w_0(dat_w_0), .pc_0(pc_0), .ack_0(ack_0), .err_0(err_0),
    .cyc_1(cyc_1), .stb_1(stb_1), .we_1(we_1), .adr_1(adr_1), .sel_1(sel_1),
    .dat_w_1(dat_w_1), .pc_1(pc_1), .ack_1(ack_1), .err_1(err_1),
    .accept_0(accept_0), .range_err_0(range_err_0),
    .wr_en_0(wr_en_0), .rd_en_0(rd_en_0),
    .wr_index_0(wr_index_0), .rd_index_0(rd_index_0), .wr_data_0(wr_data_0),
    .accept_1(accept_1), .range_err_1(range_err_1),
    .wr_en_1(wr_en_1), .rd_en_1(rd_en_1),
    .wr_index_1(wr_index_1), .rd_index_1(rd_index_1), .wr_data_1(wr_data_1)
  );

  // one bank per byte lane
  for (genvar k = 0; k < LANES; k++)
  begin : g_lane
    dram_byte_bank bank0 (
      .clk(clk),
      .wr_en_0(wr_en_0[k]), .wr_en_1(wr_en_1[k]),
      .rd_en_0(rd_en_0[k]), .rd_en_1(rd_en_1[k]),
      .wr_index_0(wr_index_0), .wr_index_1(wr_index_1),
      .rd_index_0(rd_index_0), .rd_index_1(rd_index_1),
      .wr_byte_0(wr_data_0[k*(DATA_W/LANES) +: DATA_W/LANES]),
      .wr_byte_1(wr_data_1[k*(DATA_W/LANES) +: DATA_W/LANES]),
      .rd_byte_0(rd_byte_0[k]), .rd_byte_1(rd_byte_1[k])
    );
  end

  dram_response response0 (
    .clk(clk), .rst_n(rst_n),
    .accept_0(accept_0), .accept_1(accept_1),
    .range_err_0(range_err_0), .range_err_1(range_err_1),
    .we_0(we_0), .we_1(we_1),
    .rd_byte_0(rd_byte_0), .rd_byte_1(rd_byte_1),
    .ack_0(ack_0), .ack_1(ack_1), .err_0(err_0), .err_1(err_1),
    .dat_r_0(dat_r_0), .dat_r_1(dat_r_1)
  );

endmodule

/* testbench/tb_data_ram.sv */
module tb_data_ram
  import dram_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TABLE_LEN = 16;
  localparam int RAND_PAIRS = 200;
  localparam int CYCLE_LIMIT = 16 + 4 * (TABLE_LEN + RAND_PAIRS) + 100;
  localparam int RESP_WAIT = 8;

  typedef struct packed {
    logic  act;
    logic  we;
    addr_t adr;
    sel_t  sel;
    word_t dat;
    pc_t   pc;
    word_t exp_dat;
    logic  exp_err;
    word_t mask;
  } port_op_t;

  logic  clk;
  logic  rst_n;
  logic  cyc_0, stb_0, we_0, ack_0, err_0;
  logic  cyc_1, stb_1, we_1, ack_1, err_1;
  addr_t adr_0, adr_1;
  sel_t  sel_0, sel_1;
  word_t dat_w_0, dat_w_1, dat_r_0, dat_r_1;
  pc_t   pc_0, pc_1;

  port_op_t steps_0 [TABLE_LEN];
  port_op_t steps_1 [TABLE_LEN];
  int       n_steps;
  byte_t    model_mem [DEPTH][LANES];
  logic     known [DEPTH][LANES];
  integer   seed;
  int       cycle_count;
  int       pass_count;
  int       fail_count;

  data_ram dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run stopped after %0d cycles before the tests finished", cycle_count);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic port_op_t make_op(logic act, logic we, addr_t adr, sel_t sel, word_t dat,
                                       pc_t pc, word_t exp_dat, logic exp_err);
    return '{act, we, adr, sel, dat, pc, exp_dat, exp_err, '1};
  endfunction

  task automatic add_step(port_op_t p0, port_op_t p1);
    steps_0[n_steps] = p0;
    steps_1[n_steps] = p1;
    n_steps++;
  endtask

  function automatic logic in_range(addr_t adr);
    return adr < DEPTH * LANES;
  endfunction

  // bytes that were never written are left out of the compare
  function automatic port_op_t with_expect(port_op_t p);
    index_t idx;
    idx = p.adr[INDEX_W+1:2];
    p.exp_err = p.act & ~in_range(p.adr);
    p.exp_dat = '0;
    p.mask = '1;
    if (p.act && !p.we && !p.exp_err)
    begin
      for (int k = 0; k < LANES; k++)
      begin
        p.exp_dat[k*8 +: 8] = model_mem[idx][k];
        p.mask[k*8 +: 8] = known[idx][k] ? 8'hff : 8'h00;
      end
    end
    return p;
  endfunction

  // eight words at 0x40, plus an alias of them beyond the memory
  function automatic port_op_t random_op();
    logic [31:0] r;
    port_op_t    p;
    r = $random(seed);
    p = '0;
    p.act = r[1:0] != 2'b00;
    p.we = r[2];
    if (r[6:3] == 4'd0)
      p.adr = {21'd0, 1'b1, 2'b00, 3'b010, r[10:8], 2'b00};
    else
      p.adr = {24'd0, 3'b010, r[10:8], 2'b00};
    p.sel = r[14:11];
    p.pc = {28'd0, r[18:15]};
    p.dat = $random(seed);
    return p;
  endfunction

  // the larger pc keeps a shared byte and port 1 wins a tie
  task automatic apply_writes(port_op_t p0, port_op_t p1);
    logic   w0;
    logic   w1;
    index_t i0;
    index_t i1;
    i0 = p0.adr[INDEX_W+1:2];
    i1 = p1.adr[INDEX_W+1:2];
    for (int k = 0; k < LANES; k++)
    begin
      w0 = p0.act & p0.we & in_range(p0.adr) & p0.sel[k];
      w1 = p1.act & p1.we & in_range(p1.adr) & p1.sel[k];
      if (w0 && w1 && i0 == i1)
      begin
        w0 = p0.pc > p1.pc;
        w1 = !w0;
      end
      if (w0)
      begin
        model_mem[i0][k] = p0.dat[k*8 +: 8];
        known[i0][k] = 1'b1;
      end
      if (w1)
      begin
        model_mem[i1][k] = p1.dat[k*8 +: 8];
        known[i1][k] = 1'b1;
      end
    end
  endtask

  task automatic run_op_pair(int num, port_op_t p0, port_op_t p1);
    port_op_t ops [2];
    logic     done [2];
    logic     got_ack [2];
    logic     got_err [2];
    word_t    got_dat [2];
    int       waited;
    logic     ok;
    ops[0] = p0;
    ops[1] = p1;
    done[0] = !p0.act;
    done[1] = !p1.act;
    waited = 0;
    ok = 1'b1;
    @(posedge clk);
    cyc_0   <= p0.act;
    stb_0   <= p0.act;
    we_0    <= p0.we;
    adr_0   <= p0.adr;
    sel_0   <= p0.sel;
    dat_w_0 <= p0.dat;
    pc_0    <= p0.pc;
    cyc_1   <= p1.act;
    stb_1   <= p1.act;
    we_1    <= p1.we;
    adr_1   <= p1.adr;
    sel_1   <= p1.sel;
    dat_w_1 <= p1.dat;
    pc_1    <= p1.pc;
    // outputs settle after the edge, so look at them mid cycle
    while (!(done[0] && done[1]) && waited < RESP_WAIT)
    begin
      @(negedge clk);
      waited++;
      if (!done[0] && (ack_0 || err_0))
      begin
        done[0] = 1'b1;
        got_ack[0] = ack_0;
        got_err[0] = err_0;
        got_dat[0] = dat_r_0;
      end
      if (!done[1] && (ack_1 || err_1))
      begin
        done[1] = 1'b1;
        got_ack[1] = ack_1;
        got_err[1] = err_1;
        got_dat[1] = dat_r_1;
      end
    end
    @(posedge clk);
    cyc_0 <= 1'b0;
    stb_0 <= 1'b0;
    cyc_1 <= 1'b0;
    stb_1 <= 1'b0;
    for (int n = 0; n < 2; n++)
    begin
      if (!ops[n].act)
        continue;
      if (!done[n])
      begin
        $display("port %0d timed out with no ack or err in test %0d", n, num);
        ok = 1'b0;
      end
      else if (got_err[n] != ops[n].exp_err || got_ack[n] == ops[n].exp_err)
      begin
        $display("ERR %0t: port %0d ack %b err %b, expected err %b", $time, n,
                 got_ack[n], got_err[n], ops[n].exp_err);
        ok = 1'b0;
      end
      else if ((got_dat[n] & ops[n].mask) != (ops[n].exp_dat & ops[n].mask))
      begin
        $display("ERR %0t: port %0d dat_r %h, expected %h mask %h", $time, n,
                 got_dat[n], ops[n].exp_dat, ops[n].mask);
        ok = 1'b0;
      end
    end
    if (ok)
    begin
      pass_count++;
      $display("test %0d ok", num);
    end
    else
    begin
      fail_count++;
      $display("test %0d mismatch", num);
    end
  endtask

  initial
  begin
    port_op_t p0;
    port_op_t p1;
    seed = 69;
    n_steps = 0;
    pass_count = 0;
    fail_count = 0;
    rst_n   <= 1'b0;
    cyc_0   <= 1'b0;
    stb_0   <= 1'b0;
    we_0    <= 1'b0;
    adr_0   <= '0;
    sel_0   <= '0;
    dat_w_0 <= '0;
    pc_0    <= '0;
    cyc_1   <= 1'b0;
    stb_1   <= 1'b0;
    we_1    <= 1'b0;
    adr_1   <= '0;
    sel_1   <= '0;
    dat_w_1 <= '0;
    pc_1    <= '0;
    for (int d = 0; d < DEPTH; d++)
      for (int k = 0; k < LANES; k++)
        known[d][k] = 1'b0;

    // make_op: act, we, adr, sel, dat, pc, expected dat_r, expected err
    add_step(make_op(1'b1, 1'b1, 32'h10, 4'hf, 32'h1122_3344, 32'h100, 32'h0, 1'b0), '0);
    add_step(make_op(1'b1, 1'b0, 32'h10, 4'hf, 32'h0, 32'h104, 32'h1122_3344, 1'b0), '0);
    add_step('0, make_op(1'b1, 1'b1, 32'h10, 4'h5, 32'hAABB_CCDD, 32'h108, 32'h0, 1'b0));
    add_step('0, make_op(1'b1, 1'b0, 32'h10, 4'hf, 32'h0, 32'h10C, 32'h11BB_33DD, 1'b0));
    add_step(make_op(1'b1, 1'b1, 32'h20, 4'hf, 32'hA0A0_A0A0, 32'h110, 32'h0, 1'b0),
             make_op(1'b1, 1'b1, 32'h24, 4'hf, 32'hB1B1_B1B1, 32'h114, 32'h0, 1'b0));
    add_step(make_op(1'b1, 1'b0, 32'h24, 4'hf, 32'h0, 32'h118, 32'hB1B1_B1B1, 1'b0),
             make_op(1'b1, 1'b0, 32'h20, 4'hf, 32'h0, 32'h11C, 32'hA0A0_A0A0, 1'b0));
    // same word, port 0 has the larger pc
    add_step(make_op(1'b1, 1'b1, 32'h30, 4'h7, 32'h0A0B_0C0D, 32'h200, 32'h0, 1'b0),
             make_op(1'b1, 1'b1, 32'h30, 4'hE, 32'h1A1B_1C1D, 32'h1FC, 32'h0, 1'b0));
    add_step(make_op(1'b1, 1'b0, 32'h30, 4'hf, 32'h0, 32'h204, 32'h1A0B_0C0D, 1'b0), '0);
    // equal pc goes to port 1
    add_step(make_op(1'b1, 1'b1, 32'h34, 4'hf, 32'h5555_5555, 32'h300, 32'h0, 1'b0),
             make_op(1'b1, 1'b1, 32'h34, 4'hf, 32'h6666_6666, 32'h300, 32'h0, 1'b0));
    add_step(make_op(1'b1, 1'b0, 32'h34, 4'hf, 32'h0, 32'h304, 32'h6666_6666, 1'b0),
             make_op(1'b1, 1'b0, 32'h34, 4'hf, 32'h0, 32'h308, 32'h6666_6666, 1'b0));
    add_step(make_op(1'b1, 1'b1, 32'h38, 4'hB, 32'h1234_5678, 32'h400, 32'h0, 1'b0),
             make_op(1'b1, 1'b1, 32'h38, 4'h6, 32'h8765_4321, 32'h500, 32'h0, 1'b0));
    add_step(make_op(1'b1, 1'b0, 32'h38, 4'hf, 32'h0, 32'h504, 32'h1265_4378, 1'b0), '0);
    // read beside a write to the same word sees the old data
    add_step(make_op(1'b1, 1'b1, 32'h10, 4'hf, 32'hCAFE_F00D, 32'h600, 32'h0, 1'b0),
             make_op(1'b1, 1'b0, 32'h10, 4'hf, 32'h0, 32'h604, 32'h11BB_33DD, 1'b0));
    add_step('0, make_op(1'b1, 1'b0, 32'h10, 4'hf, 32'h0, 32'h608, 32'hCAFE_F00D, 1'b0));
    add_step(make_op(1'b1, 1'b1, 32'h410, 4'hf, 32'hDEAD_BEEF, 32'h60C, 32'h0, 1'b1),
             make_op(1'b1, 1'b0, 32'h8000_0010, 4'hf, 32'h0, 32'h610, 32'h0, 1'b1));
    add_step(make_op(1'b1, 1'b0, 32'h10, 4'hf, 32'h0, 32'h614, 32'hCAFE_F00D, 1'b0), '0);

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    for (int i = 0; i < n_steps; i++)
    begin
      run_op_pair(i, steps_0[i], steps_1[i]);
      apply_writes(steps_0[i], steps_1[i]);
    end

    for (int i = 0; i < RAND_PAIRS; i++)
    begin
      p0 = random_op();
      p1 = random_op();
      if (!p0.act && !p1.act)
        p0.act = 1'b1;
      p0 = with_expect(p0);
      p1 = with_expect(p1);
      run_op_pair(n_steps + i, p0, p1);
      apply_writes(p0, p1);
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* verilog.f */
logic/dram_pkg.sv
logic/dram_request_arbiter.sv
logic/dram_byte_bank.sv
logic/dram_response.sv
logic/data_ram.sv
testbench/tb_data_ram.sv

/* run.sh */
#!/bin/sh
# build and run the data memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_data_ram -f verilog.f --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_data_ram)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
